//--- Bender.yml
package:
  name: kernel_cu

sources:
  - include_dirs:
      - common
    files:
      - common/cu_pkg.sv
      - hdl/cu_config_regs.sv
      - hdl/cu_done_hold.sv
      - setup/cu_setup_engine.sv
      - vertex/cu_vertex_engine.sv
      - arbiter/cu_memory_arbiter.sv
      - hdl/kernel_cu.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_kernel_cu.sv

//--- arbiter/cu_memory_arbiter.sv
// Memory arbiter
// Round-robin pops from two engines into one request queue, responses steered by tag

`timescale 1ns/100ps

`include "cu_defines.svh"

module cu_memory_arbiter (
  input  logic          ap_clk,
  input  logic          areset_control,
  input  logic          setup_req_valid,
  input  cu_pkg::addr_t setup_req_addr,
  input  logic          vertex_req_valid,
  input  cu_pkg::addr_t vertex_req_addr,
  input  logic          mem_stall,
  input  logic          mem_resp_valid,
  input  cu_pkg::tag_t  mem_resp_tag,
  input  cu_pkg::data_t mem_resp_data,
  output logic          setup_req_pop,
  output logic          vertex_req_pop,
  output logic          mem_req_valid,
  output cu_pkg::addr_t mem_req_addr,
  output cu_pkg::tag_t  mem_req_tag,
  output logic          setup_resp_valid,
  output logic          vertex_resp_valid,
  output cu_pkg::data_t resp_data,
  output logic          queue_empty
);

  localparam int DEPTH = `CU_ARB_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int LVL_W = $clog2(DEPTH + 1);

  // Queue storage
  cu_pkg::addr_t queue_addr [DEPTH];
  cu_pkg::tag_t  queue_tag  [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [LVL_W-1:0] level;
  logic             queue_full;

  // Round-robin priority, high favours the vertex engine
  logic             rr_ptr;
  logic             grant_setup;
  logic             grant_vertex;
  logic             push;
  cu_pkg::addr_t    push_addr;
  cu_pkg::tag_t     push_tag;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  assign queue_full  = (level == LVL_W'(DEPTH));
  assign queue_empty = (level == '0);

  // Grant the favoured engine, or the other if it is idle
  assign grant_setup  = setup_req_valid & (~rr_ptr | ~vertex_req_valid);
  assign grant_vertex = vertex_req_valid & (rr_ptr | ~setup_req_valid);

  // Pop strobes stop while the queue is full
  assign setup_req_pop  = grant_setup & ~queue_full;
  assign vertex_req_pop = grant_vertex & ~queue_full;

  assign push      = setup_req_pop | vertex_req_pop;
  assign push_addr = vertex_req_pop ? vertex_req_addr : setup_req_addr;
  assign push_tag  = vertex_req_pop ? cu_pkg::TAG_VERTEX : cu_pkg::TAG_SETUP;

  // Head leaves whenever memory is not stalling
  assign mem_req_valid = ~queue_empty & ~mem_stall;
  assign mem_req_addr  = queue_addr[rd_ptr];
  assign mem_req_tag   = queue_tag[rd_ptr];

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
      rr_ptr <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        // Other engine gets priority next
        rr_ptr <= ~vertex_req_pop;
      end
      if (mem_req_valid) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, mem_req_valid})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (push) begin
      queue_addr[wr_ptr] <= push_addr;
      queue_tag[wr_ptr]  <= push_tag;
    end
  end

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      setup_resp_valid  <= 1'b0;
      vertex_resp_valid <= 1'b0;
    end else begin
      setup_resp_valid  <= mem_resp_valid & (mem_resp_tag == cu_pkg::TAG_SETUP);
      vertex_resp_valid <= mem_resp_valid & (mem_resp_tag == cu_pkg::TAG_VERTEX);
    end
  end

  // Data is shared, the strobes say who owns it
  always_ff @(posedge ap_clk) begin
    resp_data <= mem_resp_data;
  end

endmodule : cu_memory_arbiter

//--- common/cu_defines.svh
// Compute unit parameters
// Widths, request queue depth and the done hold length

`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
// Byte address into memory
`define CU_ADDR_W 32
// Memory word, also the running sum
`define CU_DATA_W 32
// Vertex count taken from the config word
`define CU_COUNT_W 16
// Address step between consecutive words
`define CU_WORD_BYTES 4

// ----------------------------------------
// Arbiter and done filtering
// ----------------------------------------
// Entries in the shared request queue
`define CU_ARB_FIFO_DEPTH 4
// Cycles a done condition must hold
`define CU_DONE_HOLD 8

`endif

//--- common/cu_pkg.sv
// Compute unit types
// Vector typedefs, requestor tags and engine state encodings

`include "cu_defines.svh"

package cu_pkg;

  // ----------------------------------------
  // Vectors
  // ----------------------------------------
  typedef logic [`CU_ADDR_W-1:0]  addr_t;
  typedef logic [`CU_DATA_W-1:0]  data_t;
  typedef logic [`CU_COUNT_W-1:0] count_t;
  // One bit, enough for two requestors
  typedef logic                   tag_t;

  // Requestor identity on the memory port
  localparam tag_t TAG_SETUP  = 1'b0;
  localparam tag_t TAG_VERTEX = 1'b1;

  // ----------------------------------------
  // State machines
  // ----------------------------------------
  // Setup engine: config fetch, then wait for flush
  typedef enum logic [2:0] {
    SETUP_IDLE,
    SETUP_REQ,
    SETUP_WAIT_RESP,
    SETUP_WAIT_FLUSH,
    SETUP_DONE
  } setup_state_t;

  // Vertex engine: issue and sum, then hold done
  typedef enum logic [1:0] {
    VERTEX_IDLE,
    VERTEX_RUN,
    VERTEX_DONE
  } vertex_state_t;

endpackage : cu_pkg

//--- filelist.f
+incdir+common
common/cu_pkg.sv
hdl/cu_config_regs.sv
hdl/cu_done_hold.sv
setup/cu_setup_engine.sv
vertex/cu_vertex_engine.sv
arbiter/cu_memory_arbiter.sv
hdl/kernel_cu.sv
test/tb_kernel_cu.sv

//--- hdl/cu_config_regs.sv
// Descriptor register and vertex run configuration
// Emits the start pulse and holds the count written by the setup engine

`timescale 1ns/100ps

module cu_config_regs (
  input  logic           ap_clk,
  input  logic           areset_control,
  input  logic           descriptor_valid,
  input  cu_pkg::addr_t  descriptor_cfg_addr,
  input  cu_pkg::addr_t  descriptor_vertex_base,
  input  logic           count_write,
  input  cu_pkg::count_t count_data,
  output logic           start,
  output cu_pkg::addr_t  cfg_addr,
  output cu_pkg::addr_t  vertex_base,
  output cu_pkg::count_t vertex_count,
  output logic           cfg_valid
);

  // Control flags
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      start     <= 1'b0;
      cfg_valid <= 1'b0;
    end else begin
      // One cycle pulse per descriptor
      start <= descriptor_valid;
      // New descriptor invalidates the old count
      if (descriptor_valid) begin
        cfg_valid <= 1'b0;
      end else if (count_write) begin
        cfg_valid <= 1'b1;
      end
    end
  end

  // Descriptor payload
  always_ff @(posedge ap_clk) begin
    if (descriptor_valid) begin
      cfg_addr    <= descriptor_cfg_addr;
      vertex_base <= descriptor_vertex_base;
    end
    // Count from the config word
    if (count_write) begin
      vertex_count <= count_data;
    end
  end

endmodule : cu_config_regs

//--- hdl/cu_done_hold.sv
// Done filter
// Raises its output only once the condition has held CU_DONE_HOLD cycles

`timescale 1ns/100ps

`include "cu_defines.svh"

module cu_done_hold (
  input  logic ap_clk,
  input  logic areset_control,
  input  logic cond,
  output logic held
);

  localparam int HOLD_W = $clog2(`CU_DONE_HOLD + 1);

  // Consecutive cycles seen with cond high
  logic [HOLD_W-1:0] hold_cnt;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      hold_cnt <= '0;
    end else if (!cond) begin
      // Any gap restarts the count
      hold_cnt <= '0;
    end else if (hold_cnt != HOLD_W'(`CU_DONE_HOLD)) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // Saturated counter means the condition is stable
  assign held = (hold_cnt == HOLD_W'(`CU_DONE_HOLD));

endmodule : cu_done_hold

//--- hdl/kernel_cu.sv
// Graph compute unit top level
// Wires the config block, both engines, the memory arbiter and the done filters

`timescale 1ns/100ps

module kernel_cu (
  input  logic           ap_clk,
  input  logic           areset_control,
  input  logic           descriptor_valid,
  input  cu_pkg::addr_t  descriptor_cfg_addr,
  input  cu_pkg::addr_t  descriptor_vertex_base,
  input  logic           mem_stall,
  input  logic           mem_resp_valid,
  input  cu_pkg::tag_t   mem_resp_tag,
  input  cu_pkg::data_t  mem_resp_data,
  output logic           mem_req_valid,
  output cu_pkg::addr_t  mem_req_addr,
  output cu_pkg::tag_t   mem_req_tag,
  output logic           done_out,
  output cu_pkg::data_t  result_sum
);

  // ----------------------------------------
  // Config block outputs
  // ----------------------------------------
  logic           start;
  cu_pkg::addr_t  cfg_addr;
  cu_pkg::addr_t  vertex_base;
  cu_pkg::count_t vertex_count;
  logic           cfg_valid;

  // Setup engine
  logic           setup_req_valid;
  cu_pkg::addr_t  setup_req_addr;
  logic           setup_req_pop;
  logic           setup_resp_valid;
  logic           count_write;
  cu_pkg::count_t count_data;
  logic           setup_done;
  logic           flush;

  // Vertex engine
  logic           vertex_req_valid;
  cu_pkg::addr_t  vertex_req_addr;
  logic           vertex_req_pop;
  logic           vertex_resp_valid;
  logic           vertex_done;

  // Shared arbiter state
  cu_pkg::data_t  resp_data;
  logic           queue_empty;

  // Done only counts once nothing is left queued
  logic           vertex_hold_cond;
  logic           setup_hold_cond;

  assign vertex_hold_cond = vertex_done & queue_empty;
  assign setup_hold_cond  = setup_done & queue_empty;

  // ----------------------------------------
  // Descriptor and vertex run configuration
  // ----------------------------------------
  cu_config_regs config_regs (
    .ap_clk                 (ap_clk),
    .areset_control         (areset_control),
    .descriptor_valid       (descriptor_valid),
    .descriptor_cfg_addr    (descriptor_cfg_addr),
    .descriptor_vertex_base (descriptor_vertex_base),
    .count_write            (count_write),
    .count_data             (count_data),
    .start                  (start),
    .cfg_addr               (cfg_addr),
    .vertex_base            (vertex_base),
    .vertex_count           (vertex_count),
    .cfg_valid              (cfg_valid)
  );

  cu_setup_engine setup_engine (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .start          (start),
    .cfg_addr       (cfg_addr),
    .req_pop        (setup_req_pop),
    .resp_valid     (setup_resp_valid),
    .resp_data      (resp_data),
    .flush          (flush),
    .req_valid      (setup_req_valid),
    .req_addr       (setup_req_addr),
    .count_write    (count_write),
    .count_data     (count_data),
    .setup_done     (setup_done)
  );

  cu_vertex_engine vertex_engine (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .start          (start),
    .cfg_valid      (cfg_valid),
    .vertex_base    (vertex_base),
    .vertex_count   (vertex_count),
    .req_pop        (vertex_req_pop),
    .resp_valid     (vertex_resp_valid),
    .resp_data      (resp_data),
    .req_valid      (vertex_req_valid),
    .req_addr       (vertex_req_addr),
    .vertex_done    (vertex_done),
    .result_sum     (result_sum)
  );

  // ----------------------------------------
  // Memory port
  // ----------------------------------------
  cu_memory_arbiter memory_arbiter (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .setup_req_valid   (setup_req_valid),
    .setup_req_addr    (setup_req_addr),
    .vertex_req_valid  (vertex_req_valid),
    .vertex_req_addr   (vertex_req_addr),
    .mem_stall         (mem_stall),
    .mem_resp_valid    (mem_resp_valid),
    .mem_resp_tag      (mem_resp_tag),
    .mem_resp_data     (mem_resp_data),
    .setup_req_pop     (setup_req_pop),
    .vertex_req_pop    (vertex_req_pop),
    .mem_req_valid     (mem_req_valid),
    .mem_req_addr      (mem_req_addr),
    .mem_req_tag       (mem_req_tag),
    .setup_resp_valid  (setup_resp_valid),
    .vertex_resp_valid (vertex_resp_valid),
    .resp_data         (resp_data),
    .queue_empty       (queue_empty)
  );

  // Stage one: vertex done long enough flushes setup
  cu_done_hold vertex_done_hold (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .cond           (vertex_hold_cond),
    .held           (flush)
  );

  // Stage two: setup done long enough ends the run
  cu_done_hold setup_done_hold (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .cond           (setup_hold_cond),
    .held           (done_out)
  );

endmodule : kernel_cu

//--- setup/cu_setup_engine.sv
// Setup engine
// Reads the config word, passes the vertex count on, then waits for flush

`timescale 1ns/100ps

`include "cu_defines.svh"

module cu_setup_engine (
  input  logic           ap_clk,
  input  logic           areset_control,
  input  logic           start,
  input  cu_pkg::addr_t  cfg_addr,
  input  logic           req_pop,
  input  logic           resp_valid,
  input  cu_pkg::data_t  resp_data,
  input  logic           flush,
  output logic           req_valid,
  output cu_pkg::addr_t  req_addr,
  output logic           count_write,
  output cu_pkg::count_t count_data,
  output logic           setup_done
);

  cu_pkg::setup_state_t state;

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state       <= cu_pkg::SETUP_IDLE;
      count_write <= 1'b0;
    end else begin
      count_write <= 1'b0;
      case (state)
        cu_pkg::SETUP_IDLE, cu_pkg::SETUP_DONE: begin
          // Done holds until the next run
          if (start) begin
            state <= cu_pkg::SETUP_REQ;
          end
        end
        cu_pkg::SETUP_REQ: begin
          // Request level stays up until the arbiter takes it
          if (req_pop) begin
            state <= cu_pkg::SETUP_WAIT_RESP;
          end
        end
        cu_pkg::SETUP_WAIT_RESP: begin
          if (resp_valid) begin
            count_write <= 1'b1;
            state       <= cu_pkg::SETUP_WAIT_FLUSH;
          end
        end
        cu_pkg::SETUP_WAIT_FLUSH: begin
          // Vertex side has settled
          if (flush) begin
            state <= cu_pkg::SETUP_DONE;
          end
        end
        default: state <= cu_pkg::SETUP_IDLE;
      endcase
    end
  end

  // Request address and count payload
  always_ff @(posedge ap_clk) begin
    if (start) begin
      req_addr <= cfg_addr;
    end
    // Low bits of the config word give the vertex count
    if (state == cu_pkg::SETUP_WAIT_RESP && resp_valid) begin
      count_data <= resp_data[`CU_COUNT_W-1:0];
    end
  end

  assign req_valid  = (state == cu_pkg::SETUP_REQ);
  assign setup_done = (state == cu_pkg::SETUP_DONE);

endmodule : cu_setup_engine

//--- test/tb_kernel_cu.sv
// Testbench for the graph compute unit
// Memory model with random latency, directed runs, watchdog and summary

`timescale 1ns/100ps

`include "cu_defines.svh"

module tb_kernel_cu;

  // Sum of the vertex counts over all runs
  localparam int TOTAL_VERTICES  = 74;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = TOTAL_VERTICES * 20 + NUM_TESTS * 500;
  localparam logic [31:0] DATA_MASK = 32'h5a5a_0000;
  localparam logic [31:0] CFG_ADDR  = 32'h0000_1000;

  logic          ap_clk;
  logic          areset_control;
  logic          descriptor_valid;
  cu_pkg::addr_t descriptor_cfg_addr;
  cu_pkg::addr_t descriptor_vertex_base;
  logic          mem_stall;
  logic          mem_resp_valid;
  cu_pkg::tag_t  mem_resp_tag;
  cu_pkg::data_t mem_resp_data;
  logic          mem_req_valid;
  cu_pkg::addr_t mem_req_addr;
  cu_pkg::tag_t  mem_req_tag;
  logic          done_out;
  cu_pkg::data_t result_sum;

  // Memory model state
  cu_pkg::addr_t pend_addr[$];
  cu_pkg::tag_t  pend_tag[$];
  int unsigned   pend_due[$];
  cu_pkg::addr_t log_addr[$];
  cu_pkg::tag_t  log_tag[$];
  cu_pkg::data_t cfg_word;
  int unsigned   cycle;
  int unsigned   stall_hits;
  int unsigned   last_vresp_cycle;
  int unsigned   done_rise_cycle;
  logic          done_prev;
  logic          stall_random;

  // Bookkeeping
  int error_count;
  int pass_count;
  int fail_count;

  kernel_cu dut0 (
    .ap_clk                 (ap_clk),
    .areset_control         (areset_control),
    .descriptor_valid       (descriptor_valid),
    .descriptor_cfg_addr    (descriptor_cfg_addr),
    .descriptor_vertex_base (descriptor_vertex_base),
    .mem_stall              (mem_stall),
    .mem_resp_valid         (mem_resp_valid),
    .mem_resp_tag           (mem_resp_tag),
    .mem_resp_data          (mem_resp_data),
    .mem_req_valid          (mem_req_valid),
    .mem_req_addr           (mem_req_addr),
    .mem_req_tag            (mem_req_tag),
    .done_out               (done_out),
    .result_sum             (result_sum)
  );

  always #50 ap_clk = ~ap_clk;

  // Model data word at an address including the config word
  function automatic cu_pkg::data_t mem_word(cu_pkg::addr_t addr);
    if (addr == CFG_ADDR) begin
      return cfg_word;
    end
    return addr ^ DATA_MASK;
  endfunction

  function automatic cu_pkg::data_t expected_sum(cu_pkg::addr_t base, int count);
    cu_pkg::data_t sum;
    sum = '0;
    for (int i = 0; i < count; i++) begin
      sum = sum + mem_word(base + cu_pkg::addr_t'(i * 4));
    end
    return sum;
  endfunction

  // ----------------------------------------
  // Memory model and monitors
  // ----------------------------------------
  always @(posedge ap_clk) begin
    cycle     <= cycle + 1;
    done_prev <= done_out;
    if (done_out && !done_prev) begin
      done_rise_cycle <= cycle;
    end
    if (mem_resp_valid && mem_resp_tag == cu_pkg::TAG_VERTEX) begin
      last_vresp_cycle <= cycle;
    end
    if (mem_req_valid && mem_stall) begin
      stall_hits <= stall_hits + 1;
    end
    mem_resp_valid <= 1'b0;
    if (areset_control) begin
      pend_addr.delete();
      pend_tag.delete();
      pend_due.delete();
    end else begin
      // Only the head may answer so responses keep request order
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
        mem_resp_valid <= 1'b1;
        mem_resp_tag   <= pend_tag[0];
        mem_resp_data  <= mem_word(pend_addr[0]);
        void'(pend_addr.pop_front());
        void'(pend_tag.pop_front());
        void'(pend_due.pop_front());
      end
      if (mem_req_valid) begin
        pend_addr.push_back(mem_req_addr);
        pend_tag.push_back(mem_req_tag);
        pend_due.push_back(cycle + $urandom_range(1, 6));
        log_addr.push_back(mem_req_addr);
        log_tag.push_back(mem_req_tag);
      end
    end
  end

  // Random stall pattern while a test asks for it
  always @(posedge ap_clk) begin
    mem_stall <= stall_random ? 1'($urandom_range(0, 1)) : 1'b0;
  end

  // ----------------------------------------
  // Check helpers
  // ----------------------------------------
  task automatic report_mismatch(string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic finish_test(string name, int errs_before);
    if (error_count == errs_before) begin
      pass_count++;
      $display("Test %s passed", name);
    end else begin
      fail_count++;
      $display("Test %s failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  // Each vertex address once with tag 1 and the config address once with tag 0
  task automatic check_requests(cu_pkg::addr_t base, int count);
    int hits;
    cu_pkg::addr_t addr;
    if (log_addr.size() != count + 1) begin
      report_mismatch($sformatf("expected %0d requests, saw %0d", count + 1, log_addr.size()));
    end
    hits = 0;
    foreach (log_addr[j]) begin
      if (log_addr[j] == CFG_ADDR && log_tag[j] == cu_pkg::TAG_SETUP) begin
        hits++;
      end
    end
    if (hits != 1) begin
      report_mismatch($sformatf("config address requested %0d times", hits));
    end
    for (int i = 0; i < count; i++) begin
      addr = base + cu_pkg::addr_t'(i * 4);
      hits = 0;
      foreach (log_addr[j]) begin
        if (log_addr[j] == addr && log_tag[j] == cu_pkg::TAG_VERTEX) begin
          hits++;
        end
      end
      if (hits != 1) begin
        report_mismatch($sformatf("vertex address %h requested %0d times", addr, hits));
      end
    end
  endtask

  task automatic check_run(cu_pkg::addr_t base, int count);
    if (done_out !== 1'b1) begin
      report_mismatch("done_out not high at end of run");
    end
    if (result_sum !== expected_sum(base, count)) begin
      report_mismatch($sformatf("sum %h, expected %h", result_sum, expected_sum(base, count)));
    end
    check_requests(base, count);
  endtask

  // Pulse the descriptor and wait for done to drop and rise again
  task automatic run_kernel(cu_pkg::addr_t base, int count, output int drop_cycles);
    @(negedge ap_clk);
    log_addr.delete();
    log_tag.delete();
    // Upper half holds junk since only the low bits carry the count
    cfg_word = {16'hc0de, 16'(count)};
    @(posedge ap_clk);
    descriptor_valid       <= 1'b1;
    descriptor_cfg_addr    <= CFG_ADDR;
    descriptor_vertex_base <= base;
    drop_cycles = 0;
    @(negedge ap_clk);
    while (done_out && drop_cycles < 8) begin
      @(posedge ap_clk);
      descriptor_valid <= 1'b0;
      @(negedge ap_clk);
      drop_cycles++;
    end
    if (descriptor_valid) begin
      @(posedge ap_clk);
      descriptor_valid <= 1'b0;
    end
    while (!done_out) begin
      @(negedge ap_clk);
    end
    // One more cycle so the rise monitor has updated
    @(negedge ap_clk);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_idle_after_reset();
    int errs_before;
    errs_before = error_count;
    repeat (20) begin
      @(negedge ap_clk);
      if (done_out !== 1'b0 || mem_req_valid !== 1'b0 || result_sum !== '0) begin
        report_mismatch("outputs not idle after reset");
      end
    end
    finish_test("idle_after_reset", errs_before);
  endtask

  task automatic test_single_run(string name, cu_pkg::addr_t base, int count, bit stall);
    int errs_before;
    int drop_cycles;
    errs_before = error_count;
    @(negedge ap_clk);
    stall_hits   = 0;
    stall_random = stall;
    run_kernel(base, count, drop_cycles);
    stall_random = 1'b0;
    check_run(base, count);
    if (stall_hits != 0) begin
      report_mismatch($sformatf("mem_req_valid high during stall %0d times", stall_hits));
    end
    finish_test(name, errs_before);
  endtask

  task automatic test_back_to_back();
    int errs_before;
    int drop_cycles;
    errs_before = error_count;
    run_kernel(32'h0003_0000, 12, drop_cycles);
    check_run(32'h0003_0000, 12);
    run_kernel(32'h0004_0100, 7, drop_cycles);
    if (drop_cycles > 3) begin
      report_mismatch($sformatf("done_out dropped after %0d cycles", drop_cycles));
    end
    check_run(32'h0004_0100, 7);
    finish_test("back_to_back", errs_before);
  endtask

  task automatic test_done_filter();
    int errs_before;
    int drop_cycles;
    errs_before = error_count;
    run_kernel(32'h0005_0000, 5, drop_cycles);
    check_run(32'h0005_0000, 5);
    if (done_rise_cycle < last_vresp_cycle + `CU_DONE_HOLD) begin
      report_mismatch($sformatf("done rose at cycle %0d, last vertex response at %0d",
                                done_rise_cycle, last_vresp_cycle));
    end
    finish_test("done_filter", errs_before);
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial begin
    void'($urandom(32'h3409_57bc));
    ap_clk                 = 1'b0;
    areset_control         = 1'b1;
    descriptor_valid       = 1'b0;
    descriptor_cfg_addr    = '0;
    descriptor_vertex_base = '0;
    mem_stall              = 1'b0;
    mem_resp_valid         = 1'b0;
    mem_resp_tag           = cu_pkg::TAG_SETUP;
    mem_resp_data          = '0;
    stall_random           = 1'b0;
    cycle                  = 0;
    stall_hits             = 0;
    error_count            = 0;
    pass_count             = 0;
    fail_count             = 0;
    repeat (10) @(posedge ap_clk);
    areset_control <= 1'b0;
    test_idle_after_reset();
    test_single_run("count_10", 32'h0001_0000, 10, 1'b0);
    test_single_run("count_0", 32'h0002_0000, 0, 1'b0);
    test_single_run("count_40_stall", 32'h0006_0040, 40, 1'b1);
    test_back_to_back();
    test_done_filter();
    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, error_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    $display("Watchdog expired after %0d cycles, a run never finished", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : tb_kernel_cu

//--- vertex/cu_vertex_engine.sv
// Vertex engine
// Issues consecutive vertex reads and sums the returned words

`timescale 1ns/100ps

`include "cu_defines.svh"

module cu_vertex_engine (
  input  logic           ap_clk,
  input  logic           areset_control,
  input  logic           start,
  input  logic           cfg_valid,
  input  cu_pkg::addr_t  vertex_base,
  input  cu_pkg::count_t vertex_count,
  input  logic           req_pop,
  input  logic           resp_valid,
  input  cu_pkg::data_t  resp_data,
  output logic           req_valid,
  output cu_pkg::addr_t  req_addr,
  output logic           vertex_done,
  output cu_pkg::data_t  result_sum
);

  cu_pkg::vertex_state_t state;

  // Requests accepted and responses seen this run
  cu_pkg::count_t issue_cnt;
  cu_pkg::count_t resp_cnt;
  cu_pkg::count_t resp_cnt_next;

  assign resp_cnt_next = resp_cnt + 1'b1;

  // ----------------------------------------
  // Run control and summation
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state      <= cu_pkg::VERTEX_IDLE;
      issue_cnt  <= '0;
      resp_cnt   <= '0;
      result_sum <= '0;
    end else if (start) begin
      // New run clears the old result
      state      <= cu_pkg::VERTEX_IDLE;
      result_sum <= '0;
    end else begin
      case (state)
        cu_pkg::VERTEX_IDLE: begin
          if (cfg_valid) begin
            issue_cnt <= '0;
            resp_cnt  <= '0;
            // Zero vertices, nothing to fetch
            if (vertex_count == '0) begin
              state <= cu_pkg::VERTEX_DONE;
            end else begin
              state <= cu_pkg::VERTEX_RUN;
            end
          end
        end
        cu_pkg::VERTEX_RUN: begin
          if (req_pop) begin
            issue_cnt <= issue_cnt + 1'b1;
          end
          // Several reads may be in flight
          if (resp_valid) begin
            resp_cnt   <= resp_cnt_next;
            result_sum <= result_sum + resp_data;
            if (resp_cnt_next == vertex_count) begin
              state <= cu_pkg::VERTEX_DONE;
            end
          end
        end
        cu_pkg::VERTEX_DONE: begin
          // Held until the next start
          state <= cu_pkg::VERTEX_DONE;
        end
        default: state <= cu_pkg::VERTEX_IDLE;
      endcase
    end
  end

  // Address walks one word per accepted request
  always_ff @(posedge ap_clk) begin
    if (state == cu_pkg::VERTEX_IDLE && cfg_valid) begin
      req_addr <= vertex_base;
    end else if (req_pop) begin
      req_addr <= req_addr + cu_pkg::addr_t'(`CU_WORD_BYTES);
    end
  end

  // Request level until every vertex word is issued
  assign req_valid   = (state == cu_pkg::VERTEX_RUN) && (issue_cnt != vertex_count);
  assign vertex_done = (state == cu_pkg::VERTEX_DONE);

endmodule : cu_vertex_engine
